/* verilog/eeprom_pkg.sv */
package eeprom_pkg;

    // four independent two-wire buses
    localparam int NUM_CHAN = 4;
    localparam int CHAN_W   = $clog2(NUM_CHAN);

    // 2 KB part, 11 address bits
    localparam int ADDR_W = 11;

    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [7:0]        byte_t;

    // upper nibble of the control byte
    localparam logic [3:0] DEV_TAG = 4'b1010;

    // CLK cycles per quarter SCL period
    localparam int QTR_CYCLES = 1;

    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_W,     // control byte, write direction
        ADDR_LO,
        DATA_W,
        RESTART,    // repeated start before a read
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } ctrl_state_t;

endpackage

/* verilog/eeprom_dispatch.sv */
`timescale 1ns/100ps

module eeprom_dispatch (
    input  logic                                CLK,
    input  logic                                RESET,
    input  logic                                wr,
    input  logic                                rd,
    input  eeprom_pkg::chan_t                   chan,
    input  eeprom_pkg::addr_t                   addr,
    input  eeprom_pkg::byte_t                   wdata,
    output logic [eeprom_pkg::NUM_CHAN-1:0]     start_wr,
    output logic [eeprom_pkg::NUM_CHAN-1:0]     start_rd,
    output eeprom_pkg::addr_t                   req_addr,
    output eeprom_pkg::byte_t                   req_wdata,
    output logic                                reject,
    input  logic [eeprom_pkg::NUM_CHAN-1:0]     done
);
    import eeprom_pkg::*;

    logic [NUM_CHAN-1:0] busy;
    logic [NUM_CHAN-1:0] sel;       // one-hot channel decode
    logic                req;
    logic                accept;

    always_comb
    begin
        sel       = '0;
        sel[chan] = 1'b1;
    end

    assign req    = wr || rd;
    assign accept = req && !busy[chan];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start_wr <= '0;
            start_rd <= '0;
            reject   <= 1'b0;
            busy     <= '0;
        end
        else
        begin
            start_wr <= (wr && accept) ? sel : '0;
            start_rd <= (rd && accept) ? sel : '0;
            reject   <= req && busy[chan];
            busy     <= (busy & ~done) | (accept ? sel : '0); // done only hits busy channels
        end
    end

    // shared request fields, valid with the start pulse
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_addr  <= addr;
            req_wdata <= wdata;
        end
    end

    assert property (@(posedge CLK) disable iff (RESET) !(wr && rd))
        else $error("wr and rd high together");

endmodule

/* verilog/eeprom_serial_ctrl.sv */
`timescale 1ns/100ps

module eeprom_serial_ctrl (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                start_wr,
    input  logic                start_rd,
    input  eeprom_pkg::addr_t   req_addr,
    input  eeprom_pkg::byte_t   req_wdata,
    output logic                done,
    output eeprom_pkg::byte_t   rdata,
    output logic                nack,
    output logic                scl,
    output logic                sda_drive_low,
    input  logic                sda_in
);
    import eeprom_pkg::*;

    ctrl_state_t state;
    logic [3:0]  pre_cnt;       // CLK cycles within a quarter
    logic [1:0]  qtr;           // quarter of the current bit
    logic [3:0]  bit_cnt;       // 0..7 data, 8 acknowledge
    byte_t       shift_q;
    byte_t       data_q;        // write byte, later the read byte
    addr_t       addr_q;
    logic        is_rd;
    logic        tick;
    logic        bit_end;
    logic        ack_bit;
    logic        byte_state;    // master shifts a byte out
    logic        sample;        // middle of SCL high
    logic        go;

    assign go         = (state == IDLE) && (start_wr || start_rd);
    assign tick       = (pre_cnt == 4'(QTR_CYCLES - 1));
    assign bit_end    = tick && (qtr == 2'd3);
    assign sample     = tick && (qtr == 2'd2);
    assign ack_bit    = (bit_cnt == 4'd8);
    assign byte_state = state inside {CTRL_W, ADDR_LO, DATA_W, CTRL_R};

    assign done  = (state == DONE);
    assign rdata = data_q;

    always_comb
    begin
        case (state)
            IDLE, DONE: scl = 1'b1;
            START:      scl = (qtr != 2'd3);  // idle cycle is the first quarter
            STOP:       scl = (qtr != 2'd0);
            default:    scl = (qtr == 2'd1) || (qtr == 2'd2);
        endcase
    end

    always_comb
    begin
        case (state)
            START:   sda_drive_low = (qtr != 2'd0);
            RESTART: sda_drive_low = qtr[1];            // falls with scl high
            STOP:    sda_drive_low = (qtr != 2'd3);     // rises with scl high
            CTRL_W, ADDR_LO, DATA_W, CTRL_R:
                sda_drive_low = !ack_bit && !shift_q[7];
            default: sda_drive_low = 1'b0;   // idle, done, read byte, master nack
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            pre_cnt <= '0;
            qtr     <= '0;
            bit_cnt <= '0;
            nack    <= 1'b0;
        end
        else
        begin
            if (state == IDLE || tick)
                pre_cnt <= '0;
            else
                pre_cnt <= pre_cnt + 4'd1;

            if (state != IDLE && tick)
                qtr <= qtr + 2'd1;

            if (bit_end && (byte_state || state == DATA_R))
                bit_cnt <= ack_bit ? 4'd0 : bit_cnt + 4'd1;

            // high sda on the ninth clock means no acknowledge
            if (sample && byte_state && ack_bit)
                nack <= nack | sda_in;

            case (state)
                IDLE:
                    if (go)
                    begin
                        state   <= START;
                        qtr     <= 2'd1;
                        bit_cnt <= '0;
                        nack    <= 1'b0;
                    end
                START:
                    if (bit_end)
                        state <= CTRL_W;
                CTRL_W:
                    if (bit_end && ack_bit)
                        state <= ADDR_LO;
                ADDR_LO:
                    if (bit_end && ack_bit)
                        state <= is_rd ? RESTART : DATA_W;
                DATA_W:
                    if (bit_end && ack_bit)
                        state <= STOP;
                RESTART:
                    if (bit_end)
                        state <= CTRL_R;
                CTRL_R:
                    if (bit_end && ack_bit)
                        state <= DATA_R;
                DATA_R:
                    if (bit_end && ack_bit)
                        state <= STOP;
                STOP:
                    if (bit_end)
                        state <= DONE;
                DONE:
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (go)
        begin
            addr_q <= req_addr;
            data_q <= req_wdata;
            is_rd  <= start_rd;
        end
        else if (state == DATA_R && sample && !ack_bit)
            data_q <= {data_q[6:0], sda_in};    // msb first

        if (bit_end)
        begin
            case (state)
                START:   shift_q <= {DEV_TAG, addr_q[10:8], 1'b0};
                RESTART: shift_q <= {DEV_TAG, addr_q[10:8], 1'b1};
                CTRL_W:  shift_q <= ack_bit ? addr_q[7:0] : shift_q << 1;
                ADDR_LO: shift_q <= ack_bit ? data_q : shift_q << 1;
                default: shift_q <= shift_q << 1;
            endcase
        end
    end

    // dispatcher must hold requests while this channel is busy
    assert property (@(posedge CLK) disable iff (RESET)
        (start_wr || start_rd) |-> (state == IDLE))
        else $error("start pulse while controller not idle");

    assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_drive_low) && !(state inside {START, RESTART, STOP}))
            |-> (!scl && !$past(scl)))
        else $error("sda changed while scl high");

endmodule

/* verilog/eeprom_collect.sv */
`timescale 1ns/100ps

module eeprom_collect (
    input  logic                                        CLK,
    input  logic                                        RESET,
    input  logic [eeprom_pkg::NUM_CHAN-1:0]             done,
    input  eeprom_pkg::byte_t [eeprom_pkg::NUM_CHAN-1:0] rdata,
    input  logic [eeprom_pkg::NUM_CHAN-1:0]             nack,
    output logic                                        res_valid,
    output eeprom_pkg::chan_t                           res_chan,
    output eeprom_pkg::byte_t                           res_data,
    output logic                                        res_nack
);
    import eeprom_pkg::*;

    logic [NUM_CHAN-1:0]  pend;
    byte_t [NUM_CHAN-1:0] pend_data;
    logic [NUM_CHAN-1:0]  pend_nack;
    logic [NUM_CHAN-1:0]  cand;     // pending or completing now
    logic [NUM_CHAN-1:0]  grant;
    chan_t                last;     // last delivered channel
    chan_t                pick;
    logic                 found;

    always_comb
    begin
        chan_t idx;
        cand  = pend | done;
        found = 1'b0;
        pick  = last;
        grant = '0;
        for (int k = 1; k <= NUM_CHAN; k++)
        begin
            idx = chan_t'((int'(last) + k) % NUM_CHAN);
            if (!found && cand[idx])
            begin
                found = 1'b1;
                pick  = idx;
            end
        end
        if (found)
            grant[pick] = 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pend      <= '0;
            res_valid <= 1'b0;
            last      <= chan_t'(NUM_CHAN - 1);     // channel 0 first
        end
        else
        begin
            pend      <= cand & ~grant;
            res_valid <= found;
            if (found)
                last <= pick;
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < NUM_CHAN; i++)
        begin
            if (done[i])
            begin
                pend_data[i] <= rdata[i];
                pend_nack[i] <= nack[i];
            end
        end
        res_chan <= pick;
        res_data <= done[pick] ? rdata[pick] : pend_data[pick];    // bypass fresh result
        res_nack <= done[pick] ? nack[pick] : pend_nack[pick];
    end

    assert property (@(posedge CLK) disable iff (RESET) (done & pend) == '0)
        else $error("done for a channel with an undelivered result");

endmodule

/* verilog/eeprom_bus_top.sv */
`timescale 1ns/100ps

module eeprom_bus_top (
    input  logic                                CLK,
    input  logic                                RESET,
    input  logic                                wr,
    input  logic                                rd,
    input  eeprom_pkg::chan_t                   chan,
    input  eeprom_pkg::addr_t                   addr,
    input  eeprom_pkg::byte_t                   wdata,
    output logic                                reject,
    output logic                                res_valid,
    output eeprom_pkg::chan_t                   res_chan,
    output eeprom_pkg::byte_t                   res_data,
    output logic                                res_nack,
    output logic [eeprom_pkg::NUM_CHAN-1:0]     scl,
    output logic [eeprom_pkg::NUM_CHAN-1:0]     sda_drive_low,
    input  logic [eeprom_pkg::NUM_CHAN-1:0]     sda_in
);
    import eeprom_pkg::*;

    logic [NUM_CHAN-1:0]  start_wr;
    logic [NUM_CHAN-1:0]  start_rd;
    logic [NUM_CHAN-1:0]  done;
    logic [NUM_CHAN-1:0]  nack;
    byte_t [NUM_CHAN-1:0] rdata;
    addr_t                req_addr;
    byte_t                req_wdata;

    eeprom_dispatch u_dispatch (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .chan       (chan),
        .addr       (addr),
        .wdata      (wdata),
        .start_wr   (start_wr),
        .start_rd   (start_rd),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .reject     (reject),
        .done       (done)
    );

    // one bus controller per channel
    for (genvar g = 0; g < NUM_CHAN; g++)
    begin : g_chan
        eeprom_serial_ctrl u_ctrl (
            .CLK            (CLK),
            .RESET          (RESET),
            .start_wr       (start_wr[g]),
            .start_rd       (start_rd[g]),
            .req_addr       (req_addr),
            .req_wdata      (req_wdata),
            .done           (done[g]),
            .rdata          (rdata[g]),
            .nack           (nack[g]),
            .scl            (scl[g]),
            .sda_drive_low  (sda_drive_low[g]),
            .sda_in         (sda_in[g])
        );
    end

    eeprom_collect u_collect (
        .CLK        (CLK),
        .RESET      (RESET),
        .done       (done),
        .rdata      (rdata),
        .nack       (nack),
        .res_valid  (res_valid),
        .res_chan   (res_chan),
        .res_data   (res_data),
        .res_nack   (res_nack)
    );

endmodule

/* test/eeprom_model.sv */
`timescale 1ns/100ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic en,
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low,
    output int   viol_cnt
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {P_CTRL, P_ADDR, P_DATA, P_RD, P_END} phase_t;

    byte_t      mem [0:2047];
    phase_t     phase;
    logic       prev_scl;
    logic       prev_sda;
    logic       in_txn;
    logic       seen;       // scl rose within the current bit
    logic       rd_live;
    logic [3:0] bitn;
    byte_t      shreg;
    byte_t      out_q;
    byte_t      first_ctrl;
    logic [2:0] page;
    byte_t      lo;
    logic       rise;
    logic       fall;
    logic       start_ev;
    logic       stop_ev;
    logic       ctrl_done;

    assign rise      = !prev_scl && scl;
    assign fall      = prev_scl && !scl && seen;
    assign start_ev  = prev_scl && scl && prev_sda && !sda;
    assign stop_ev   = prev_scl && scl && !prev_sda && sda;
    assign ctrl_done = fall && (bitn == 4'd7) && (phase == P_CTRL);

    initial
        viol_cnt = 0;

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            prev_scl      <= 1'b1;
            prev_sda      <= 1'b1;
            in_txn        <= 1'b0;
            seen          <= 1'b0;
            rd_live       <= 1'b0;
            bitn          <= '0;
            phase         <= P_CTRL;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (start_ev || stop_ev)
            begin
                in_txn        <= start_ev;
                seen          <= 1'b0;
                rd_live       <= 1'b0;
                bitn          <= '0;
                phase         <= P_CTRL;
                sda_drive_low <= 1'b0;
            end
            else if (rise)
            begin
                seen <= 1'b1;
                if (bitn < 4'd8 && phase != P_RD)
                    shreg <= {shreg[6:0], sda};
            end
            else if (fall)
            begin
                seen <= 1'b0;
                bitn <= (bitn == 4'd8) ? 4'd0 : bitn + 4'd1;
                if (phase == P_RD && rd_live)
                begin
                    out_q         <= out_q << 1;
                    sda_drive_low <= en && (bitn < 4'd7) && !out_q[6];  // master acks the 9th
                    if (bitn == 4'd8)
                        phase <= P_END;
                end
                else if (bitn == 4'd8)
                begin
                    sda_drive_low <= 1'b0;
                    if (phase == P_RD)
                    begin
                        rd_live       <= 1'b1;
                        out_q         <= mem[{page, lo}];
                        sda_drive_low <= en && !mem[{page, lo}][7];
                    end
                end
                else if (bitn == 4'd7)
                begin
                    sda_drive_low <= en && (phase != P_END);    // acknowledge
                    case (phase)
                        P_CTRL:
                            if (shreg[0])
                                phase <= P_RD;
                            else
                            begin
                                page       <= shreg[3:1];
                                first_ctrl <= shreg;
                                phase      <= P_ADDR;
                            end
                        P_ADDR:
                        begin
                            lo    <= shreg;
                            phase <= P_DATA;
                        end
                        P_DATA:
                        begin
                            if (en)
                                mem[{page, lo}] <= shreg;
                            phase <= P_END;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    task automatic log_violation(input string msg);
        $display("protocol violation at %0t, %s", $time, msg);
        viol_cnt++;
    endtask

    assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda) && prev_scl && scl) |-> (bitn == 4'd0))
        else log_violation("sda changed while scl high inside a byte");

    assert property (@(posedge CLK) disable iff (RESET) rise |-> in_txn)
        else log_violation("scl clocked without a start condition");

    // only a read may restart, after its address byte
    assert property (@(posedge CLK) disable iff (RESET)
        (start_ev && in_txn) |-> (phase == P_DATA))
        else log_violation("start without a stop ending the previous transaction");

    assert property (@(posedge CLK) disable iff (RESET)
        ctrl_done |-> (shreg[7:4] == DEV_TAG))
        else log_violation("control byte with a wrong device tag");

    assert property (@(posedge CLK) disable iff (RESET)
        (ctrl_done && shreg[0]) |-> (shreg[7:1] == first_ctrl[7:1]))
        else log_violation("repeated start with a different tag or page");

endmodule

/* test/eeprom_bus_tb.sv */
`timescale 1ns/100ps

module eeprom_bus_tb;
    import eeprom_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int DEPTH     = 64;

    logic                CLK;
    logic                RESET;
    logic                wr;
    logic                rd;
    chan_t               chan;
    addr_t               addr;
    byte_t               wdata;
    logic                reject;
    logic                res_valid;
    chan_t               res_chan;
    byte_t               res_data;
    logic                res_nack;
    logic [NUM_CHAN-1:0] scl;
    logic [NUM_CHAN-1:0] sda_drive_low;
    logic [NUM_CHAN-1:0] slave_low;
    logic [NUM_CHAN-1:0] sda_bus;
    logic [NUM_CHAN-1:0] en_m;
    int                  viol [NUM_CHAN];

    byte_t               mem_sb [NUM_CHAN][2048];
    byte_t               exp_data [NUM_CHAN][DEPTH];
    logic                exp_nack [NUM_CHAN][DEPTH];
    logic                exp_rd [NUM_CHAN][DEPTH];
    logic [5:0]          head [NUM_CHAN];
    logic [5:0]          tail [NUM_CHAN];
    logic [NUM_CHAN-1:0] busy_m;
    logic                exp_rej;
    logic                started;
    logic                head_any;
    byte_t               head_data;
    logic                head_nack;
    logic                head_rd;
    logic [15:0]         lfsr;
    int                  err_cnt;
    int                  test_cnt;

    assign sda_bus = ~(sda_drive_low | slave_low);     // wired-AND with pullup

    eeprom_bus_top uut (
        .CLK            (CLK),
        .RESET          (RESET),
        .wr             (wr),
        .rd             (rd),
        .chan           (chan),
        .addr           (addr),
        .wdata          (wdata),
        .reject         (reject),
        .res_valid      (res_valid),
        .res_chan       (res_chan),
        .res_data       (res_data),
        .res_nack       (res_nack),
        .scl            (scl),
        .sda_drive_low  (sda_drive_low),
        .sda_in         (sda_bus)
    );

    function automatic byte_t init_byte(input addr_t a);
        return a[7:0] ^ {5'b0, a[10:8]};
    endfunction

    for (genvar g = 0; g < NUM_CHAN; g++)
    begin : g_bus
        eeprom_model u_model (
            .CLK            (CLK),
            .RESET          (RESET),
            .en             (en_m[g]),
            .scl            (scl[g]),
            .sda            (sda_bus[g]),
            .sda_drive_low  (slave_low[g]),
            .viol_cnt       (viol[g])
        );
        initial
        begin
            for (int a = 0; a < 2048; a++)
                u_model.mem[a] <= init_byte(addr_t'(a));
        end
    end

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial
    begin
        #(NUM_TESTS * 4 * 200 * 40);
        $display("timeout, results still outstanding");
        $display("ERRORS FOUND");
        $finish;
    end

    // expected outcome of every accepted request, per channel in issue order
    always @(posedge CLK)
    begin
        if (RESET)
        begin
            busy_m  <= '0;
            exp_rej <= 1'b0;
            started <= 1'b0;
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                head[i] <= '0;
                tail[i] <= '0;
            end
        end
        else
        begin
            exp_rej <= (wr || rd) && busy_m[chan];
            if (wr || rd)
                started <= 1'b1;
            if (res_valid)
            begin
                head[res_chan]   <= head[res_chan] + 6'd1;
                busy_m[res_chan] <= 1'b0;
            end
            if ((wr || rd) && !busy_m[chan])
            begin
                busy_m[chan]                <= 1'b1;
                exp_rd[chan][tail[chan]]    <= rd;
                exp_nack[chan][tail[chan]]  <= !en_m[chan];
                exp_data[chan][tail[chan]]  <= en_m[chan] ? mem_sb[chan][addr] : 8'hff;
                tail[chan]                  <= tail[chan] + 6'd1;
                if (wr && en_m[chan])
                    mem_sb[chan][addr] <= wdata;
            end
        end
    end

    always_comb
    begin
        head_any  = head[res_chan] != tail[res_chan];
        head_data = exp_data[res_chan][head[res_chan]];
        head_nack = exp_nack[res_chan][head[res_chan]];
        head_rd   = exp_rd[res_chan][head[res_chan]];
    end

    assert property (@(posedge CLK) disable iff (RESET)
        !started |-> (&scl && !(|sda_drive_low) && !res_valid && !reject))
        else
        begin
            $display("bus or result activity before the first request at %0t", $time);
            err_cnt++;
        end

    assert property (@(posedge CLK) disable iff (RESET) reject == exp_rej)
        else
        begin
            $display("ERR %0t reject exp %b got %b", $time, $sampled(exp_rej), $sampled(reject));
            err_cnt++;
        end

    assert property (@(posedge CLK) disable iff (RESET) res_valid |-> head_any)
        else
        begin
            $display("result on channel %0d with no request outstanding", $sampled(res_chan));
            err_cnt++;
        end

    assert property (@(posedge CLK) disable iff (RESET)
        (res_valid && head_any && head_rd) |-> (res_data == head_data))
        else
        begin
            $display("ERR %0t res_data exp %h got %h", $time, $sampled(head_data),
                $sampled(res_data));
            err_cnt++;
        end

    assert property (@(posedge CLK) disable iff (RESET)
        (res_valid && head_any) |-> (res_nack == head_nack))
        else
        begin
            $display("ERR %0t res_nack exp %b got %b", $time, $sampled(head_nack),
                $sampled(res_nack));
            err_cnt++;
        end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic outstanding();
        for (int i = 0; i < NUM_CHAN; i++)
            if (head[i] != tail[i])
                return 1'b1;
        return 1'b0;
    endfunction

    // checker failures plus bus protocol violations seen by the models
    function automatic int total_errors();
        int n;
        n = err_cnt;
        for (int i = 0; i < NUM_CHAN; i++)
            n += viol[i];
        return n;
    endfunction

    // one-cycle strobe, called 5 ns after a rising edge
    task automatic issue(input logic is_rd, input int ch, input addr_t a, input byte_t d);
        wr    = !is_rd;
        rd    = is_rd;
        chan  = chan_t'(ch);
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #5;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge CLK);
        #5;
    endtask

    task automatic wait_results();
        @(posedge CLK);
        #5;
        while (outstanding())
        begin
            @(posedge CLK);
            #5;
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s finished, %0d errors so far", test_cnt, name, total_errors());
    endtask

    initial
    begin
        logic [31:0] r;
        addr_t       ra [NUM_CHAN];
        byte_t       rv [NUM_CHAN];

        wr       = 1'b0;
        rd       = 1'b0;
        chan     = '0;
        addr     = '0;
        wdata    = '0;
        en_m     = '1;
        RESET    = 1'b1;
        lfsr     = 16'd35;
        err_cnt  = 0;
        test_cnt = 0;
        for (int c = 0; c < NUM_CHAN; c++)
            for (int a = 0; a < 2048; a++)
                mem_sb[c][a] <= init_byte(addr_t'(a));
        repeat (16) @(posedge CLK);
        #5;
        RESET = 1'b0;
        repeat (10) @(posedge CLK);
        #5;
        end_test("reset state");

        for (int c = 0; c < NUM_CHAN; c++)
        begin
            take_bits(11, r);
            ra[c] = addr_t'(r);
            take_bits(8, r);
            rv[c] = byte_t'(r);
        end
        for (int c = 0; c < NUM_CHAN; c++)
            issue(1'b0, c, ra[c], rv[c]);
        wait_results();
        for (int c = 0; c < NUM_CHAN; c++)
            issue(1'b1, c, ra[c], 8'h00);
        wait_results();
        for (int c = 0; c < NUM_CHAN; c++)
            issue(1'b1, c, ra[c] ^ 11'h0ff, 8'h00);     // unwritten, init pattern
        wait_results();
        for (int c = 0; c < NUM_CHAN; c++)
            issue(1'b0, c, ra[c] ^ 11'h500, ~rv[c]);    // same low byte, other page
        wait_results();
        for (int c = 0; c < NUM_CHAN; c++)
            issue(1'b1, c, ra[c], 8'h00);
        wait_results();
        for (int c = 0; c < NUM_CHAN; c++)
            issue(1'b1, c, ra[c] ^ 11'h500, 8'h00);
        wait_results();
        end_test("write and read back");

        issue(1'b0, 1, ra[1], 8'h5a);
        issue(1'b1, 1, ra[1], 8'h00);   // busy, refused
        wait_results();
        issue(1'b1, 1, ra[1], 8'h00);
        wait_results();
        end_test("busy reject");

        issue(1'b1, 0, ra[0], 8'h00);
        issue(1'b0, 1, ra[1], 8'h3c);
        issue(1'b1, 2, ra[2], 8'h00);
        issue(1'b0, 3, ra[3], 8'hc3);
        wait_results();
        // writes 40 cycles behind the reads, so two channels finish per cycle
        issue(1'b1, 0, ra[0], 8'h00);
        issue(1'b1, 2, ra[2], 8'h00);
        idle_cycles(38);
        issue(1'b0, 1, ra[1], 8'h96);
        issue(1'b0, 3, ra[3], 8'h69);
        wait_results();
        for (int c = 0; c < NUM_CHAN; c++)
            issue(1'b1, c, ra[c], 8'h00);
        wait_results();
        end_test("all channels back to back");

        en_m[2] = 1'b0;
        issue(1'b0, 2, ra[2], 8'h77);
        issue(1'b1, 0, ra[0], 8'h00);
        issue(1'b1, 3, ra[3], 8'h00);
        wait_results();
        issue(1'b1, 2, ra[2], 8'h00);
        issue(1'b1, 1, ra[1], 8'h00);
        wait_results();
        en_m[2] = 1'b1;
        issue(1'b1, 2, ra[2], 8'h00);
        wait_results();
        end_test("missing acknowledge");

        $display("%0d tests run, %0d errors", test_cnt, total_errors());
        if (total_errors() == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* eeprom_bus_top.f */
verilog/eeprom_pkg.sv
verilog/eeprom_dispatch.sv
verilog/eeprom_serial_ctrl.sv
verilog/eeprom_collect.sv
verilog/eeprom_bus_top.sv
test/eeprom_model.sv
test/eeprom_bus_tb.sv

/* Makefile */
SIM := obj_dir/Veeprom_bus_tb

all: check

$(SIM): eeprom_bus_top.f verilog/*.sv test/*.sv
	verilator --binary --timing --assert --top-module eeprom_bus_tb -f eeprom_bus_top.f

run: $(SIM)
	./$(SIM) | tee sim.log

check: run
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run check clean
